// ==== all.f ====
+incdir+include
src/sched_stream_pkg.sv
src/sched_queue_pkg.sv
src/sched_ifs.sv
src/enqueue_agent.sv
src/pkt_buffer.sv
src/buffer_arbiter.sv
src/pifo_calendar.sv
src/port_dequeue.sv
src/sched_top.sv
dv/sched_props.sv
dv/sched_tb.sv

// ==== dv/sched_props.sv ====
`timescale 1ns/10ps
`include "sched_defs.svh"

module sched_props (
    input logic                         axis_aclk,
    input logic                         axis_resetn,
    input logic                         m_axis_0_tvalid,
    input logic                         m_axis_0_tready,
    input sched_stream_pkg::data_word_t m_axis_0_tdata,
    input sched_stream_pkg::rank_t      m_axis_0_trank,
    input logic                         m_axis_1_tvalid,
    input logic                         m_axis_1_tready,
    input sched_stream_pkg::data_word_t m_axis_1_tdata,
    input sched_stream_pkg::rank_t      m_axis_1_trank,
    input sched_queue_pkg::q_depth_t    q_size_0,
    input sched_queue_pkg::q_depth_t    q_size_1
);

    ////////////////////////////////////////////////////////////
    // output register under back-pressure
    ////////////////////////////////////////////////////////////

    hold_0: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        m_axis_0_tvalid && !m_axis_0_tready |=>
        m_axis_0_tvalid && $stable(m_axis_0_tdata) && $stable(m_axis_0_trank))
        else $error("port 0 word changed or vanished while stalled");

    hold_1: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        m_axis_1_tvalid && !m_axis_1_tready |=>
        m_axis_1_tvalid && $stable(m_axis_1_tdata) && $stable(m_axis_1_trank))
        else $error("port 1 word changed or vanished while stalled");

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge axis_aclk)
        $rose(axis_resetn) |-> !m_axis_0_tvalid && !m_axis_1_tvalid)
        else $error("output valid in the first cycle after reset");

    // calendar occupancy bound
    depth_bound: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        q_size_0 <= `SCHED_PIFO_DEPTH && q_size_1 <= `SCHED_PIFO_DEPTH)
        else $error("queue size above calendar depth");

endmodule

bind sched_top sched_props props_i (
    .axis_aclk       (axis_aclk),
    .axis_resetn     (axis_resetn),
    .m_axis_0_tvalid (m_axis_0_tvalid),
    .m_axis_0_tready (m_axis_0_tready),
    .m_axis_0_tdata  (m_axis_0_tdata),
    .m_axis_0_trank  (m_axis_0_trank),
    .m_axis_1_tvalid (m_axis_1_tvalid),
    .m_axis_1_tready (m_axis_1_tready),
    .m_axis_1_tdata  (m_axis_1_tdata),
    .m_axis_1_trank  (m_axis_1_trank),
    .q_size_0        (q_size_0),
    .q_size_1        (q_size_1)
);

// ==== dv/sched_tb.sv ====
`timescale 1ns/10ps
`include "sched_defs.svh"

module sched_tb;
    import sched_stream_pkg::*;
    import sched_queue_pkg::*;

    localparam int TIMEOUT_CYCLES = 600;
    localparam int NP             = `SCHED_NUM_PORTS;
    // model word is {rank, data}
    localparam int MW             = `SCHED_RANK_W + `SCHED_DATA_W;

    logic        axis_aclk;
    logic        axis_resetn;
    logic        s_axis_tvalid;
    data_word_t  s_axis_tdata;
    tuser_t      s_axis_tuser;
    logic        m_axis_0_tready;
    logic        m_axis_0_tvalid;
    data_word_t  m_axis_0_tdata;
    rank_t       m_axis_0_trank;
    q_depth_t    q_size_0;
    logic        m_axis_1_tready;
    logic        m_axis_1_tvalid;
    data_word_t  m_axis_1_tdata;
    rank_t       m_axis_1_trank;
    q_depth_t    q_size_1;
    logic [15:0] drop_count;

    // reference model, per port the expected output order
    logic [MW-1:0] exp_q [NP][$];
    // 1 while the port's first entry already sits in the output register
    int            held [NP];
    int            buf_used;
    int            exp_drops;
    int            seq;
    int            seed;
    int            errors;
    int            checks;
    int            received;
    int            cycle_count;

    sched_top dut_i (
        .axis_aclk       (axis_aclk),
        .axis_resetn     (axis_resetn),
        .s_axis_tvalid   (s_axis_tvalid),
        .s_axis_tdata    (s_axis_tdata),
        .s_axis_tuser    (s_axis_tuser),
        .m_axis_0_tready (m_axis_0_tready),
        .m_axis_0_tvalid (m_axis_0_tvalid),
        .m_axis_0_tdata  (m_axis_0_tdata),
        .m_axis_0_trank  (m_axis_0_trank),
        .q_size_0        (q_size_0),
        .m_axis_1_tready (m_axis_1_tready),
        .m_axis_1_tvalid (m_axis_1_tvalid),
        .m_axis_1_tdata  (m_axis_1_tdata),
        .m_axis_1_trank  (m_axis_1_trank),
        .q_size_1        (q_size_1),
        .drop_count      (drop_count)
    );

    initial
    begin
        axis_aclk = 1'b0;
        forever
        begin
            #10 axis_aclk = ~axis_aclk;
        end
    end

    ////////////////////////////////////////////////////////////
    // drive helpers
    ////////////////////////////////////////////////////////////

    // inputs change 2 ns past the edge
    task automatic tick();
        @(posedge axis_aclk);
        #2;
    endtask

    task automatic drive_input(input logic sched_valid, input int port,
                               input rank_t rank, input data_word_t data);
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = data;
        s_axis_tuser  = '0;
        s_axis_tuser[`SCHED_TUSER_VALID_BIT] = sched_valid;
        s_axis_tuser[`SCHED_TUSER_PORT_BIT]  = port[0];
        s_axis_tuser[`SCHED_TUSER_RANK_LSB +: `SCHED_RANK_W] = rank;
        tick();
        s_axis_tvalid = 1'b0;
    endtask

    // idle port pops this at once, so it leads the output order
    task automatic load_head(input int port);
        data_word_t data;
        data = 32'h4000_0000 | data_word_t'(seq);
        seq++;
        exp_q[port].push_back({rank_t'(0), data});
        held[port] = 1;
        drive_input(1'b1, port, rank_t'(0), data);
    endtask

    // only while both output registers are loaded and stalled
    task automatic send_pkt(input logic sched_valid, input int port, input rank_t rank);
        data_word_t data;
        int         pos;
        int         pending;
        data    = 32'h5000_0000 | data_word_t'(seq);
        seq++;
        pending = exp_q[port].size() - held[port];
        if (sched_valid && pending < `SCHED_PIFO_DEPTH && buf_used < `SCHED_BUF_DEPTH)
        begin
            // behind every entry of lower or equal rank
            pos = exp_q[port].size();
            for (int i = exp_q[port].size() - 1; i >= held[port]; i--)
            begin
                if (exp_q[port][i][MW-1 -: `SCHED_RANK_W] > rank)
                begin
                    pos = i;
                end
            end
            exp_q[port].insert(pos, {rank, data});
            buf_used++;
        end
        else
        begin
            exp_drops++;
        end
        drive_input(sched_valid, port, rank, data);
    endtask

    task automatic wait_heads();
        while (!(m_axis_0_tvalid && m_axis_1_tvalid))
        begin
            tick();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_counts();
        int want_0;
        int want_1;
        want_0 = exp_q[0].size() - held[0];
        want_1 = exp_q[1].size() - held[1];
        checks++;
        assert (q_size_0 == want_0 && q_size_1 == want_1)
        else
        begin
            $display("MISMATCH at %0t: q_size %0d/%0d, expected %0d/%0d",
                     $time, q_size_0, q_size_1, want_0, want_1);
            errors++;
        end
        assert (drop_count == exp_drops)
        else
        begin
            $display("MISMATCH at %0t: drop_count %0d, expected %0d",
                     $time, drop_count, exp_drops);
            errors++;
        end
    endtask

    // a transfer seen here completes at the next rising edge
    task automatic check_output(input int port, input logic valid, input logic ready,
                                input rank_t rank, input data_word_t data);
        logic [MW-1:0] want;
        if (valid && ready)
        begin
            checks++;
            received++;
            assert (exp_q[port].size() > 0)
            else
            begin
                $display("port %0d delivered a word at %0t that was never admitted",
                         port, $time);
                errors++;
            end
            if (exp_q[port].size() > 0)
            begin
                want = exp_q[port].pop_front();
                assert ({rank, data} == want)
                else
                begin
                    $display("MISMATCH at %0t: port %0d rank %0d data %h, expected %0d %h",
                             $time, port, rank, data, want[MW-1 -: `SCHED_RANK_W],
                             want[`SCHED_DATA_W-1:0]);
                    errors++;
                end
                if (held[port] > 0)
                begin
                    held[port]--;
                end
                else
                begin
                    buf_used--;
                end
            end
        end
    endtask

    always @(negedge axis_aclk)
    begin
        if (axis_resetn)
        begin
            check_output(0, m_axis_0_tvalid, m_axis_0_tready, m_axis_0_trank, m_axis_0_tdata);
            check_output(1, m_axis_1_tvalid, m_axis_1_tready, m_axis_1_trank, m_axis_1_tdata);
        end
    end

    // random tready on both ports until the model runs dry
    task automatic drain();
        logic [31:0] rnd;
        while (exp_q[0].size() > 0 || exp_q[1].size() > 0)
        begin
            rnd = $random(seed);
            m_axis_0_tready = rnd[0];
            m_axis_1_tready = rnd[3];
            tick();
        end
        m_axis_0_tready = 1'b0;
        m_axis_1_tready = 1'b0;
        repeat (3) tick();
        check_counts();
        assert (!m_axis_0_tvalid && !m_axis_1_tvalid)
        else
        begin
            $display("an output still held a word after the model drained");
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        seed            = 77;
        seq             = 0;
        errors          = 0;
        checks          = 0;
        received        = 0;
        buf_used        = 0;
        exp_drops       = 0;
        held[0]         = 0;
        held[1]         = 0;
        axis_resetn     = 1'b0;
        s_axis_tvalid   = 1'b0;
        s_axis_tdata    = '0;
        s_axis_tuser    = '0;
        m_axis_0_tready = 1'b0;
        m_axis_1_tready = 1'b0;
        repeat (4) @(posedge axis_aclk);
        #2;
        axis_resetn = 1'b1;

        // reset state
        check_counts();
        assert (!m_axis_0_tvalid && !m_axis_1_tvalid)
        else
        begin
            $display("an output was valid right after reset");
            errors++;
        end

        // rank order, routing and invalid drop, outputs stalled
        load_head(0);
        load_head(1);
        wait_heads();
        // narrow rank range forces ties
        for (int i = 0; i < 6; i++)
        begin
            send_pkt(1'b1, 0, rank_t'(10 + ($random(seed) & 3)));
        end
        for (int i = 0; i < 3; i++)
        begin
            send_pkt(1'b1, 1, rank_t'($random(seed) & 15));
        end
        send_pkt(1'b0, 0, rank_t'(1));
        check_counts();
        drain();

        // calendar full on port 0, then buffer full on port 1
        load_head(0);
        load_head(1);
        wait_heads();
        for (int i = 0; i < 9; i++)
        begin
            send_pkt(1'b1, 0, rank_t'($random(seed) & 15));
        end
        check_counts();
        for (int i = 0; i < 5; i++)
        begin
            send_pkt(1'b1, 1, rank_t'($random(seed) & 15));
        end
        check_counts();
        drain();

        $display("summary: %0d checks, %0d words received, %0d errors",
                 checks, received, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge axis_aclk);
            cycle_count++;
        end
        $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== include/sched_defs.svh ====
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// output ports behind the shared buffer
`define SCHED_NUM_PORTS 2

// stream widths
`define SCHED_DATA_W 32
`define SCHED_RANK_W 8
`define SCHED_TUSER_W 16

// user word layout
// bit 15 schedule valid, bit 8 destination port, bits 7..0 rank
`define SCHED_TUSER_VALID_BIT 15
`define SCHED_TUSER_RANK_LSB 0
`define SCHED_TUSER_PORT_BIT 8

// storage sizes
`define SCHED_BUF_DEPTH 12
`define SCHED_PIFO_DEPTH 8

`endif

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module sched_tb -o sched_sim

out=$(./obj_dir/sched_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== src/buffer_arbiter.sv ====
`timescale 1ns/10ps
`include "sched_defs.svh"

module buffer_arbiter (
    input  logic                         axis_aclk,
    input  logic                         axis_resetn,
    input  sched_stream_pkg::data_word_t rd_data,
    output logic                         rd_strobe,
    output sched_queue_pkg::buf_addr_t   rd_addr,
    buf_rd_if.arbiter                    rd_ports [`SCHED_NUM_PORTS]
);
    import sched_stream_pkg::*;
    import sched_queue_pkg::*;

    localparam int NP = `SCHED_NUM_PORTS;

    logic [NP-1:0] req;
    logic [NP-1:0] grant;
    logic [NP-1:0] valid_q;
    buf_addr_t     req_addr [NP];
    port_idx_t     rr_ptr;
    port_idx_t     grant_idx;

    for (genvar g = 0; g < NP; g++) begin : gen_port
        assign req[g]               = rd_ports[g].rd_req;
        assign req_addr[g]          = rd_ports[g].rd_addr;
        assign rd_ports[g].rd_grant = grant[g];
        // data fans out to all, valid marks the owner
        assign rd_ports[g].rd_valid = valid_q[g];
        assign rd_ports[g].rd_data  = rd_data;
    end

    // search from the rotating pointer, first requester wins
    always_comb
    begin
        grant     = '0;
        grant_idx = rr_ptr;
        for (int k = NP - 1; k >= 0; k--)
        begin
            if (req[(int'(rr_ptr) + k) % NP])
            begin
                grant_idx = port_idx_t'((int'(rr_ptr) + k) % NP);
            end
        end
        grant[grant_idx] = req[grant_idx];
    end

    assign rd_strobe = |grant;
    assign rd_addr   = req_addr[grant_idx];

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            rr_ptr  <= '0;
            valid_q <= '0;
        end
        else
        begin
            valid_q <= grant;
            // winner goes to the back of the line
            if (rd_strobe)
            begin
                rr_ptr <= port_idx_t'((int'(grant_idx) + 1) % NP);
            end
        end
    end

endmodule

// ==== src/enqueue_agent.sv ====
`timescale 1ns/10ps
`include "sched_defs.svh"

module enqueue_agent (
    input  logic                         axis_aclk,
    input  logic                         axis_resetn,
    input  logic                         in_valid,
    input  sched_stream_pkg::data_word_t in_data,
    input  sched_stream_pkg::tuser_t     in_tuser,
    input  sched_queue_pkg::buf_addr_t   alloc_addr,
    input  logic                         buf_full,
    output logic                         alloc_strobe,
    output sched_stream_pkg::data_word_t wr_data,
    output logic [15:0]                  drop_count,
    pifo_if.producer                     pifo_ports [`SCHED_NUM_PORTS]
);
    import sched_stream_pkg::*;
    import sched_queue_pkg::*;

    logic                        sched_valid;
    rank_t                       in_rank;
    port_idx_t                   in_port;
    logic [`SCHED_NUM_PORTS-1:0] port_full;
    logic                        admit;

    // user word fields
    assign sched_valid = in_tuser[`SCHED_TUSER_VALID_BIT];
    assign in_rank     = in_tuser[`SCHED_TUSER_RANK_LSB +: `SCHED_RANK_W];
    assign in_port     = in_tuser[`SCHED_TUSER_PORT_BIT +: $bits(port_idx_t)];

    // all three must hold, else the packet is lost
    assign admit = in_valid && sched_valid && !port_full[in_port] && !buf_full;

    // word goes straight into the free slot at the list head
    assign alloc_strobe = admit;
    assign wr_data      = in_data;

    for (genvar g = 0; g < `SCHED_NUM_PORTS; g++) begin : gen_port
        assign port_full[g] = pifo_ports[g].full;
        // insert only at the destination calendar
        assign pifo_ports[g].ins_strobe = admit && (in_port == port_idx_t'(g));
        assign pifo_ports[g].ins_entry  = {in_rank, alloc_addr};
    end

    // drop counter, one per refused strobe
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            drop_count <= '0;
        end
        else if (in_valid && !admit)
        begin
            drop_count <= drop_count + 16'd1;
        end
    end

endmodule

// ==== src/pifo_calendar.sv ====
`timescale 1ns/10ps
`include "sched_defs.svh"

module pifo_calendar (
    input logic       axis_aclk,
    input logic       axis_resetn,
    pifo_if.calendar  pifo
);
    import sched_queue_pkg::*;

    localparam int D        = `SCHED_PIFO_DEPTH;
    localparam int RANK_MSB = $bits(pifo_entry_t) - 1;

    pifo_entry_t entries [D];
    pifo_entry_t shifted [D];
    pifo_entry_t nxt     [D];
    q_depth_t    depth;
    q_depth_t    cnt_after_pop;
    q_depth_t    ins_pos;

    assign pifo.head_entry = entries[0];
    assign pifo.depth      = depth;
    assign pifo.empty      = (depth == '0);
    assign pifo.full       = (depth == q_depth_t'(D));

    // pop first, then place the new entry in the shifted array
    always_comb
    begin
        shifted       = entries;
        cnt_after_pop = depth;
        if (pifo.pop_strobe)
        begin
            for (int i = 0; i < D - 1; i++)
            begin
                shifted[i] = entries[i + 1];
            end
            cnt_after_pop = depth - 1'b1;
        end

        // first strictly higher rank, so ties keep arrival order
        ins_pos = cnt_after_pop;
        for (int i = D - 1; i >= 0; i--)
        begin
            if (i < int'(cnt_after_pop) &&
                shifted[i][RANK_MSB -: `SCHED_RANK_W] >
                pifo.ins_entry[RANK_MSB -: `SCHED_RANK_W])
            begin
                ins_pos = q_depth_t'(i);
            end
        end

        nxt = shifted;
        if (pifo.ins_strobe)
        begin
            for (int i = 0; i < D; i++)
            begin
                if (i == int'(ins_pos))
                begin
                    nxt[i] = pifo.ins_entry;
                end
                else if (i > int'(ins_pos))
                begin
                    nxt[i] = shifted[i - 1];
                end
            end
        end
    end

    // next sorted order from the insert and pop logic
    always_ff @(posedge axis_aclk)
    begin
        entries <= nxt;
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            depth <= '0;
        end
        else if (pifo.ins_strobe && !pifo.pop_strobe)
        begin
            depth <= depth + 1'b1;
        end
        else if (pifo.pop_strobe && !pifo.ins_strobe)
        begin
            depth <= depth - 1'b1;
        end
    end

endmodule

// ==== src/pkt_buffer.sv ====
`timescale 1ns/10ps
`include "sched_defs.svh"

module pkt_buffer (
    input  logic                         axis_aclk,
    input  logic                         axis_resetn,
    input  logic                         alloc_strobe,
    input  sched_stream_pkg::data_word_t wr_data,
    input  logic                         rd_strobe,
    input  sched_queue_pkg::buf_addr_t   rd_addr,
    output sched_queue_pkg::buf_addr_t   alloc_addr,
    output logic                         buf_full,
    output sched_stream_pkg::data_word_t rd_data
);
    import sched_stream_pkg::*;
    import sched_queue_pkg::*;

    localparam buf_addr_t LAST = buf_addr_t'(`SCHED_BUF_DEPTH - 1);

    data_word_t          mem       [`SCHED_BUF_DEPTH];
    buf_addr_t           free_list [`SCHED_BUF_DEPTH];
    buf_addr_t           fl_head;
    buf_addr_t           fl_tail;
    logic [BUF_ADDR_W:0] free_cnt;

    // next free slot sits at the list head
    assign alloc_addr = free_list[fl_head];
    assign buf_full   = (free_cnt == '0);

    ////////////////////////////////////////////////////////////
    // free list
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // every slot starts free
            for (int i = 0; i < `SCHED_BUF_DEPTH; i++)
            begin
                free_list[i] <= buf_addr_t'(i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            free_cnt <= (BUF_ADDR_W + 1)'(`SCHED_BUF_DEPTH);
        end
        else
        begin
            if (alloc_strobe)
            begin
                fl_head <= (fl_head == LAST) ? '0 : fl_head + 1'b1;
            end
            // read slot goes back to the tail
            if (rd_strobe)
            begin
                free_list[fl_tail] <= rd_addr;
                fl_tail <= (fl_tail == LAST) ? '0 : fl_tail + 1'b1;
            end
            if (alloc_strobe && !rd_strobe)
            begin
                free_cnt <= free_cnt - 1'b1;
            end
            else if (rd_strobe && !alloc_strobe)
            begin
                free_cnt <= free_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // data memory
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (alloc_strobe)
        begin
            mem[alloc_addr] <= wr_data;
        end
        // one cycle read latency
        if (rd_strobe)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== src/port_dequeue.sv ====
`timescale 1ns/10ps
`include "sched_defs.svh"

module port_dequeue (
    input  logic                         axis_aclk,
    input  logic                         axis_resetn,
    input  logic                         tready,
    output logic                         tvalid,
    output sched_stream_pkg::data_word_t tdata,
    output sched_stream_pkg::rank_t      trank,
    pifo_if.consumer                     pifo,
    buf_rd_if.requester                  rd
);
    import sched_stream_pkg::*;
    import sched_queue_pkg::*;

    localparam int RANK_MSB = $bits(pifo_entry_t) - 1;

    // busy from pop until the word comes back
    logic      busy;
    logic      req_q;
    buf_addr_t slot_q;
    rank_t     rank_q;

    // one word in the output register, one read in flight
    assign pifo.pop_strobe = !busy && (!tvalid || tready) && !pifo.empty;

    assign rd.rd_req  = req_q;
    assign rd.rd_addr = slot_q;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            busy   <= 1'b0;
            req_q  <= 1'b0;
            tvalid <= 1'b0;
        end
        else
        begin
            if (pifo.pop_strobe)
            begin
                busy  <= 1'b1;
                req_q <= 1'b1;
            end
            else if (rd.rd_valid)
            begin
                busy <= 1'b0;
            end
            // hold the request until granted
            if (rd.rd_grant)
            begin
                req_q <= 1'b0;
            end
            // output slot is always free when data returns
            if (rd.rd_valid)
            begin
                tvalid <= 1'b1;
            end
            else if (tready)
            begin
                tvalid <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge axis_aclk)
    begin
        if (pifo.pop_strobe)
        begin
            rank_q <= pifo.head_entry[RANK_MSB -: `SCHED_RANK_W];
            slot_q <= pifo.head_entry[BUF_ADDR_W-1:0];
        end
        if (rd.rd_valid)
        begin
            tdata <= rd.rd_data;
            trank <= rank_q;
        end
    end

endmodule

// ==== src/sched_ifs.sv ====
`timescale 1ns/10ps

////////////////////////////////////////////////////////////
// calendar port, one per output
////////////////////////////////////////////////////////////

interface pifo_if;
    logic                        ins_strobe;
    sched_queue_pkg::pifo_entry_t ins_entry;
    logic                        full;
    logic                        pop_strobe;
    sched_queue_pkg::pifo_entry_t head_entry;
    logic                        empty;
    sched_queue_pkg::q_depth_t   depth;

    // enqueue side
    modport producer (output ins_strobe, output ins_entry, input full);

    // the sorted store itself
    modport calendar (input ins_strobe, input ins_entry, input pop_strobe,
                      output full, output head_entry, output empty, output depth);

    // dequeue engine side
    modport consumer (output pop_strobe, input head_entry, input empty);
endinterface

////////////////////////////////////////////////////////////
// buffer read path, one per output
////////////////////////////////////////////////////////////

interface buf_rd_if;
    logic                         rd_req;
    sched_queue_pkg::buf_addr_t   rd_addr;
    logic                         rd_grant;
    logic                         rd_valid;
    sched_stream_pkg::data_word_t rd_data;

    // req and addr held until the grant pulse
    modport requester (output rd_req, output rd_addr,
                       input rd_grant, input rd_valid, input rd_data);
    modport arbiter (input rd_req, input rd_addr,
                     output rd_grant, output rd_valid, output rd_data);
endinterface

// ==== src/sched_queue_pkg.sv ====
`include "sched_defs.svh"

package sched_queue_pkg;

    // slot index into the shared buffer
    localparam int BUF_ADDR_W = $clog2(`SCHED_BUF_DEPTH);

    // occupancy has to reach the full depth, hence the +1
    localparam int Q_DEPTH_W = $clog2(`SCHED_PIFO_DEPTH + 1);

    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    // calendar entry, rank in the upper bits, slot below
    typedef logic [`SCHED_RANK_W+BUF_ADDR_W-1:0] pifo_entry_t;

    typedef logic [Q_DEPTH_W-1:0] q_depth_t;

endpackage

// ==== src/sched_stream_pkg.sv ====
`include "sched_defs.svh"

package sched_stream_pkg;

    // one packet is one data word
    typedef logic [`SCHED_DATA_W-1:0] data_word_t;

    // lower rank leaves first
    typedef logic [`SCHED_RANK_W-1:0] rank_t;

    // destination port index
    typedef logic [$clog2(`SCHED_NUM_PORTS)-1:0] port_idx_t;

    // raw user word as it arrives on the input strobe
    typedef logic [`SCHED_TUSER_W-1:0] tuser_t;

endpackage

// ==== src/sched_top.sv ====
`timescale 1ns/10ps
`include "sched_defs.svh"

module sched_top (
    input  logic                         axis_aclk,
    input  logic                         axis_resetn,

    // input strobe, no back-pressure
    input  logic                         s_axis_tvalid,
    input  sched_stream_pkg::data_word_t s_axis_tdata,
    input  sched_stream_pkg::tuser_t     s_axis_tuser,

    // port 0
    input  logic                         m_axis_0_tready,
    output logic                         m_axis_0_tvalid,
    output sched_stream_pkg::data_word_t m_axis_0_tdata,
    output sched_stream_pkg::rank_t      m_axis_0_trank,
    output sched_queue_pkg::q_depth_t    q_size_0,

    // port 1
    input  logic                         m_axis_1_tready,
    output logic                         m_axis_1_tvalid,
    output sched_stream_pkg::data_word_t m_axis_1_tdata,
    output sched_stream_pkg::rank_t      m_axis_1_trank,
    output sched_queue_pkg::q_depth_t    q_size_1,

    output logic [15:0]                  drop_count
);
    import sched_stream_pkg::*;
    import sched_queue_pkg::*;

    localparam int NP = `SCHED_NUM_PORTS;

    // enqueue to buffer
    logic       alloc_strobe;
    data_word_t wr_data;
    buf_addr_t  alloc_addr;
    logic       buf_full;

    // arbiter to buffer
    logic       rd_strobe;
    buf_addr_t  rd_addr;
    data_word_t rd_data;

    // per-port outputs gathered into arrays
    logic [NP-1:0] tready_vec;
    logic [NP-1:0] tvalid_vec;
    data_word_t    tdata_vec  [NP];
    rank_t         trank_vec  [NP];
    q_depth_t      q_size_vec [NP];

    pifo_if   pifo_bus [NP] ();
    buf_rd_if rd_bus   [NP] ();

    enqueue_agent u_enqueue (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .in_valid     (s_axis_tvalid),
        .in_data      (s_axis_tdata),
        .in_tuser     (s_axis_tuser),
        .alloc_addr   (alloc_addr),
        .buf_full     (buf_full),
        .alloc_strobe (alloc_strobe),
        .wr_data      (wr_data),
        .drop_count   (drop_count),
        .pifo_ports   (pifo_bus)
    );

    pkt_buffer u_buffer (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .alloc_strobe (alloc_strobe),
        .wr_data      (wr_data),
        .rd_strobe    (rd_strobe),
        .rd_addr      (rd_addr),
        .alloc_addr   (alloc_addr),
        .buf_full     (buf_full),
        .rd_data      (rd_data)
    );

    buffer_arbiter u_arbiter (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .rd_data     (rd_data),
        .rd_strobe   (rd_strobe),
        .rd_addr     (rd_addr),
        .rd_ports    (rd_bus)
    );

    ////////////////////////////////////////////////////////////
    // one calendar and one dequeue engine per port
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NP; g++) begin : gen_port
        pifo_calendar u_calendar (
            .axis_aclk   (axis_aclk),
            .axis_resetn (axis_resetn),
            .pifo        (pifo_bus[g])
        );

        port_dequeue u_dequeue (
            .axis_aclk   (axis_aclk),
            .axis_resetn (axis_resetn),
            .tready      (tready_vec[g]),
            .tvalid      (tvalid_vec[g]),
            .tdata       (tdata_vec[g]),
            .trank       (trank_vec[g]),
            .pifo        (pifo_bus[g]),
            .rd          (rd_bus[g])
        );

        assign q_size_vec[g] = pifo_bus[g].depth;
    end

    // flat port names
    assign tready_vec      = {m_axis_1_tready, m_axis_0_tready};
    assign m_axis_0_tvalid = tvalid_vec[0];
    assign m_axis_0_tdata  = tdata_vec[0];
    assign m_axis_0_trank  = trank_vec[0];
    assign q_size_0        = q_size_vec[0];
    assign m_axis_1_tvalid = tvalid_vec[1];
    assign m_axis_1_tdata  = tdata_vec[1];
    assign m_axis_1_trank  = trank_vec[1];
    assign q_size_1        = q_size_vec[1];

endmodule
